/* logic/aes_dma_settings.svh */
`ifndef AES_DMA_SETTINGS_SVH
`define AES_DMA_SETTINGS_SVH

//////////////////////////////
// Data path widths
//////////////////////////////

// Memory word
`define AES_WORD_W 32

// One cipher block
`define AES_BLOCK_W 128

`define AES_WORDS_PER_BLOCK 4

// Lanes working side by side, one block each per chunk
`define AES_LANES 2

//////////////////////////////
// Address steps in bytes
//////////////////////////////

`define AES_WORD_STEP 4

`define AES_BLOCK_STEP 16

// One chunk holds one block per lane
`define AES_CHUNK_STEP 32

`endif

/* logic/aes_mem_pkg.sv */
`include "aes_dma_settings.svh"

package aes_mem_pkg;

    //////////////////////////////
    // Memory side types
    //////////////////////////////

    // One word on the read or write port
    typedef logic [`AES_WORD_W-1:0] word_t;

    // Byte address
    typedef logic [31:0] addr_t;

    // Number of chunks in a job
    typedef logic [31:0] chunk_cnt_t;

    // Word position inside a block, 0 is the most significant word
    typedef logic [$clog2(`AES_WORDS_PER_BLOCK)-1:0] word_idx_t;

endpackage

/* logic/aes_block_pkg.sv */
`include "aes_dma_settings.svh"

package aes_block_pkg;

    //////////////////////////////
    // Cipher side types
    //////////////////////////////

    // First word read lands in the top bits
    typedef logic [`AES_BLOCK_W-1:0] block_t;

    // Lane 0 takes the first block of a chunk, lane 1 the second
    typedef logic [$clog2(`AES_LANES)-1:0] lane_sel_t;

endpackage

/* logic/chunk_reader.sv */
`timescale 1ns/1ps
`include "aes_dma_settings.svh"

module chunk_reader import aes_mem_pkg::*, aes_block_pkg::*; (
    input  logic       aes_clk,
    input  logic       aes_rst_n,
    input  logic       start,
    input  chunk_cnt_t num_chunks,
    input  addr_t      rd_base,
    output logic       rd_req,
    output addr_t      rd_addr,
    input  logic       rd_ack,
    input  word_t      rd_data,
    output logic       blk0_req,
    output block_t     blk0_data,
    output logic       blk0_last,
    input  logic       blk0_ack,
    output logic       blk1_req,
    output block_t     blk1_data,
    output logic       blk1_last,
    input  logic       blk1_ack
);

    typedef enum logic [2:0] {
        st_idle,
        st_rd,
        st_rd_end,
        st_blk,
        st_blk_end
    } rd_state_t;

    rd_state_t  state;
    addr_t      chunk_addr;
    chunk_cnt_t chunks_left;
    lane_sel_t  lane;
    word_idx_t  idx;
    block_t     blk_buf;
    logic       last_chunk;
    logic       tgt_ack;

    assign last_chunk = (chunks_left == chunk_cnt_t'(1));
    assign tgt_ack    = (lane == lane_sel_t'(1)) ? blk1_ack : blk0_ack;

    // Offset follows the memory layout of chunk, block and word
    assign rd_addr = chunk_addr
                   + addr_t'(lane) * addr_t'(`AES_BLOCK_STEP)
                   + addr_t'(idx) * addr_t'(`AES_WORD_STEP);

    // Only the target lane sees a request for the shared block
    assign blk0_data = blk_buf;
    assign blk1_data = blk_buf;
    assign blk0_last = last_chunk;
    assign blk1_last = last_chunk;

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge aes_clk or negedge aes_rst_n) begin
        if (!aes_rst_n) begin
            state       <= st_idle;
            rd_req      <= 1'b0;
            blk0_req    <= 1'b0;
            blk1_req    <= 1'b0;
            chunk_addr  <= '0;
            chunks_left <= '0;
            lane        <= '0;
            idx         <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        chunk_addr  <= rd_base;
                        chunks_left <= num_chunks;
                        lane        <= '0;
                        idx         <= '0;
                        rd_req      <= 1'b1;
                        state       <= st_rd;
                    end
                end
                st_rd: begin
                    if (rd_ack) begin
                        rd_req <= 1'b0;
                        state  <= st_rd_end;
                    end
                end
                st_rd_end: begin
                    if (!rd_ack) begin
                        if (idx == word_idx_t'(`AES_WORDS_PER_BLOCK - 1)) begin
                            blk0_req <= (lane == lane_sel_t'(0));
                            blk1_req <= (lane == lane_sel_t'(1));
                            state    <= st_blk;
                        end else begin
                            idx    <= idx + word_idx_t'(1);
                            rd_req <= 1'b1;
                            state  <= st_rd;
                        end
                    end
                end
                st_blk: begin
                    if (tgt_ack) begin
                        blk0_req <= 1'b0;
                        blk1_req <= 1'b0;
                        state    <= st_blk_end;
                    end
                end
                st_blk_end: begin
                    if (!tgt_ack) begin
                        idx <= '0;
                        if (lane == lane_sel_t'(0)) begin
                            lane   <= lane_sel_t'(1);
                            rd_req <= 1'b1;
                            state  <= st_rd;
                        end else if (last_chunk) begin
                            state <= st_idle;
                        end else begin
                            lane        <= lane_sel_t'(0);
                            chunk_addr  <= chunk_addr + addr_t'(`AES_CHUNK_STEP);
                            chunks_left <= chunks_left - chunk_cnt_t'(1);
                            rd_req      <= 1'b1;
                            state       <= st_rd;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // First word read ends up on top of the block
    always_ff @(posedge aes_clk) begin
        if (state == st_rd && rd_ack) begin
            blk_buf <= {blk_buf[`AES_BLOCK_W-`AES_WORD_W-1:0], rd_data};
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Start only between jobs
    a_no_start_busy: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        start |-> state == st_idle);

    a_chunks_nonzero: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        start |-> num_chunks != '0);

    a_rd_addr_stable: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        rd_req |=> !rd_req || $stable(rd_addr));

endmodule

/* logic/cipher_lane.sv */
`timescale 1ns/1ps

module cipher_lane import aes_block_pkg::*; (
    input  logic   aes_clk,
    input  logic   aes_rst_n,
    input  logic   blk_req,
    input  block_t blk_data,
    input  logic   blk_last,
    output logic   blk_ack,
    output logic   eng_req,
    output block_t eng_block,
    input  logic   eng_ack,
    input  block_t eng_result,
    output logic   res_req,
    output block_t res_data,
    output logic   res_last,
    input  logic   res_ack
);

    typedef enum logic [1:0] {
        slot_empty,
        slot_cipher,
        slot_result
    } slot_state_t;

    slot_state_t state;
    block_t      blk_buf;
    block_t      res_buf;
    logic        last_buf;

    assign eng_block = blk_buf;
    assign res_data  = res_buf;
    assign res_last  = last_buf;

    //////////////////////////////
    // Slot FSM
    //////////////////////////////

    always_ff @(posedge aes_clk or negedge aes_rst_n) begin
        if (!aes_rst_n) begin
            state   <= slot_empty;
            blk_ack <= 1'b0;
            eng_req <= 1'b0;
            res_req <= 1'b0;
        end else begin
            case (state)
                // Take a block, start the engine once the reader has let go
                slot_empty: begin
                    if (!blk_ack && blk_req) begin
                        blk_ack <= 1'b1;
                    end else if (blk_ack && !blk_req) begin
                        blk_ack <= 1'b0;
                        eng_req <= 1'b1;
                        state   <= slot_cipher;
                    end
                end
                slot_cipher: begin
                    if (eng_req && eng_ack) begin
                        eng_req <= 1'b0;
                    end else if (!eng_req && !eng_ack) begin
                        res_req <= 1'b1;
                        state   <= slot_result;
                    end
                end
                // Slot frees up only after the writer has taken the result
                slot_result: begin
                    if (res_req && res_ack) begin
                        res_req <= 1'b0;
                    end else if (!res_req && !res_ack) begin
                        state <= slot_empty;
                    end
                end
                default: state <= slot_empty;
            endcase
        end
    end

    // Block and flag captured on the ack edge
    always_ff @(posedge aes_clk) begin
        if (state == slot_empty && !blk_ack && blk_req) begin
            blk_buf  <= blk_data;
            last_buf <= blk_last;
        end
    end

    // Engine result only valid while its ack is high
    always_ff @(posedge aes_clk) begin
        if (state == slot_cipher && eng_req && eng_ack) begin
            res_buf <= eng_result;
        end
    end

    a_eng_block_stable: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        eng_req |=> !eng_req || $stable(eng_block));

endmodule

/* logic/result_writer.sv */
`timescale 1ns/1ps
`include "aes_dma_settings.svh"

module result_writer import aes_mem_pkg::*, aes_block_pkg::*; (
    input  logic   aes_clk,
    input  logic   aes_rst_n,
    input  logic   start,
    input  addr_t  wr_base,
    input  logic   res0_req,
    input  block_t res0_data,
    input  logic   res0_last,
    output logic   res0_ack,
    input  logic   res1_req,
    input  block_t res1_data,
    input  logic   res1_last,
    output logic   res1_ack,
    output logic   wr_req,
    output addr_t  wr_addr,
    output word_t  wr_data,
    input  logic   wr_ack,
    output logic   complete
);

    typedef enum logic [1:0] {
        st_idle,
        st_take,
        st_write,
        st_write_end
    } wr_state_t;

    wr_state_t state;
    addr_t     chunk_addr;
    lane_sel_t lane;
    word_idx_t idx;
    block_t    wr_buf;
    logic      last_buf;
    logic      cur_req;
    logic      cur_ack;
    block_t    cur_data;
    logic      cur_last;

    // Current lane's result port
    assign cur_req  = (lane == lane_sel_t'(1)) ? res1_req  : res0_req;
    assign cur_ack  = (lane == lane_sel_t'(1)) ? res1_ack  : res0_ack;
    assign cur_data = (lane == lane_sel_t'(1)) ? res1_data : res0_data;
    assign cur_last = (lane == lane_sel_t'(1)) ? res1_last : res0_last;

    assign wr_addr = chunk_addr
                   + addr_t'(lane) * addr_t'(`AES_BLOCK_STEP)
                   + addr_t'(idx) * addr_t'(`AES_WORD_STEP);
    assign wr_data = wr_buf[`AES_BLOCK_W-1 -: `AES_WORD_W];

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge aes_clk or negedge aes_rst_n) begin
        if (!aes_rst_n) begin
            state      <= st_idle;
            res0_ack   <= 1'b0;
            res1_ack   <= 1'b0;
            wr_req     <= 1'b0;
            complete   <= 1'b0;
            chunk_addr <= '0;
            lane       <= '0;
            idx        <= '0;
        end else begin
            complete <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        chunk_addr <= wr_base;
                        lane       <= '0;
                        state      <= st_take;
                    end
                end
                st_take: begin
                    if (!cur_ack && cur_req) begin
                        res0_ack <= (lane == lane_sel_t'(0));
                        res1_ack <= (lane == lane_sel_t'(1));
                    end else if (cur_ack && !cur_req) begin
                        res0_ack <= 1'b0;
                        res1_ack <= 1'b0;
                        idx      <= '0;
                        wr_req   <= 1'b1;
                        state    <= st_write;
                    end
                end
                st_write: begin
                    if (wr_ack) begin
                        wr_req <= 1'b0;
                        state  <= st_write_end;
                    end
                end
                st_write_end: begin
                    if (!wr_ack) begin
                        if (idx != word_idx_t'(`AES_WORDS_PER_BLOCK - 1)) begin
                            idx    <= idx + word_idx_t'(1);
                            wr_req <= 1'b1;
                            state  <= st_write;
                        end else if (lane == lane_sel_t'(0)) begin
                            lane  <= lane_sel_t'(1);
                            state <= st_take;
                        end else if (last_buf) begin
                            // Lane 1 closes the final chunk
                            complete <= 1'b1;
                            state    <= st_idle;
                        end else begin
                            lane       <= lane_sel_t'(0);
                            chunk_addr <= chunk_addr + addr_t'(`AES_CHUNK_STEP);
                            state      <= st_take;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Latch a result, then shift one word up per finished write
    always_ff @(posedge aes_clk) begin
        if (state == st_take && !cur_ack && cur_req) begin
            wr_buf   <= cur_data;
            last_buf <= cur_last;
        end else if (state == st_write_end && !wr_ack) begin
            wr_buf <= wr_buf << `AES_WORD_W;
        end
    end

    a_wr_data_stable: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        wr_req |=> !wr_req || $stable(wr_data));

endmodule

/* logic/aes_dma_top.sv */
`timescale 1ns/1ps

module aes_dma_top import aes_mem_pkg::*, aes_block_pkg::*; (
    input  logic       aes_clk,
    input  logic       aes_rst_n,
    input  logic       start,
    input  chunk_cnt_t num_chunks,
    input  addr_t      rd_base,
    input  addr_t      wr_base,
    output logic       complete,
    // Memory read port
    output logic       rd_req,
    output addr_t      rd_addr,
    input  logic       rd_ack,
    input  word_t      rd_data,
    // Memory write port
    output logic       wr_req,
    output addr_t      wr_addr,
    output word_t      wr_data,
    input  logic       wr_ack,
    // Cipher engine ports
    output logic       eng0_req,
    output block_t     eng0_block,
    input  logic       eng0_ack,
    input  block_t     eng0_result,
    output logic       eng1_req,
    output block_t     eng1_block,
    input  logic       eng1_ack,
    input  block_t     eng1_result
);

    //////////////////////////////
    // Reader to lanes
    //////////////////////////////

    logic   blk0_req;
    block_t blk0_data;
    logic   blk0_last;
    logic   blk0_ack;
    logic   blk1_req;
    block_t blk1_data;
    logic   blk1_last;
    logic   blk1_ack;

    //////////////////////////////
    // Lanes to writer
    //////////////////////////////

    logic   res0_req;
    block_t res0_data;
    logic   res0_last;
    logic   res0_ack;
    logic   res1_req;
    block_t res1_data;
    logic   res1_last;
    logic   res1_ack;

    chunk_reader u_reader (
        .aes_clk   (aes_clk),
        .aes_rst_n (aes_rst_n),
        .start     (start),
        .num_chunks(num_chunks),
        .rd_base   (rd_base),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data),
        .blk0_req  (blk0_req),
        .blk0_data (blk0_data),
        .blk0_last (blk0_last),
        .blk0_ack  (blk0_ack),
        .blk1_req  (blk1_req),
        .blk1_data (blk1_data),
        .blk1_last (blk1_last),
        .blk1_ack  (blk1_ack)
    );

    // First block of each chunk
    cipher_lane u_lane0 (
        .aes_clk   (aes_clk),
        .aes_rst_n (aes_rst_n),
        .blk_req   (blk0_req),
        .blk_data  (blk0_data),
        .blk_last  (blk0_last),
        .blk_ack   (blk0_ack),
        .eng_req   (eng0_req),
        .eng_block (eng0_block),
        .eng_ack   (eng0_ack),
        .eng_result(eng0_result),
        .res_req   (res0_req),
        .res_data  (res0_data),
        .res_last  (res0_last),
        .res_ack   (res0_ack)
    );

    // Second block of each chunk
    cipher_lane u_lane1 (
        .aes_clk   (aes_clk),
        .aes_rst_n (aes_rst_n),
        .blk_req   (blk1_req),
        .blk_data  (blk1_data),
        .blk_last  (blk1_last),
        .blk_ack   (blk1_ack),
        .eng_req   (eng1_req),
        .eng_block (eng1_block),
        .eng_ack   (eng1_ack),
        .eng_result(eng1_result),
        .res_req   (res1_req),
        .res_data  (res1_data),
        .res_last  (res1_last),
        .res_ack   (res1_ack)
    );

    result_writer u_writer (
        .aes_clk  (aes_clk),
        .aes_rst_n(aes_rst_n),
        .start    (start),
        .wr_base  (wr_base),
        .res0_req (res0_req),
        .res0_data(res0_data),
        .res0_last(res0_last),
        .res0_ack (res0_ack),
        .res1_req (res1_req),
        .res1_data(res1_data),
        .res1_last(res1_last),
        .res1_ack (res1_ack),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_ack   (wr_ack),
        .complete (complete)
    );

endmodule

/* test/tb_aes_dma_tests.svh */
`ifndef TB_AES_DMA_TESTS_SVH
`define TB_AES_DMA_TESTS_SVH

//////////////////////////////
// Expected values
//////////////////////////////

// Key word w lines up with block word w, first word in the top bits
function automatic logic [31:0] key_word(input int w);
    return eng_key[127 - 32 * w -: 32];
endfunction

// Writes come in address order, one per source word, each XOR the key word
task automatic check_writes(input int n, input logic [31:0] rbase, input logic [31:0] wbase);
    int          total;
    logic [31:0] exp_data;
    total = n * words_per_chunk;
    if (wr_log_addr.size() != total) begin
        report_err($sformatf("%0d writes seen, expected %0d", wr_log_addr.size(), total));
    end
    for (int i = 0; i < wr_log_addr.size() && i < total; i++) begin
        exp_data = read_word(rbase + 4 * i) ^ key_word(i % 4);
        if (wr_log_addr[i] != wbase + 4 * i) begin
            report_err($sformatf("write %0d at %h, expected address %h",
                                 i, wr_log_addr[i], wbase + 4 * i));
        end else if (wr_log_data[i] != exp_data) begin
            report_err($sformatf("write %0d at %h got %h, expected %h",
                                 i, wr_log_addr[i], wr_log_data[i], exp_data));
        end
    end
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic idle_after_reset();
    int errs_before;
    errs_before = err_count;
    repeat (20) begin
        @(posedge aes_clk);
        if (rd_req || wr_req || eng0_req || eng1_req || complete) begin
            report_err("req or complete output high before any start");
        end
    end
    finish_test("idle after reset", errs_before);
endtask

task automatic single_chunk_job();
    int errs_before;
    errs_before = err_count;
    set_delays(0, 0, 0, 0);
    run_job(1, 32'h0000_1000, 32'h0000_8000);
    check_writes(1, 32'h0000_1000, 32'h0000_8000);
    finish_test("single chunk", errs_before);
endtask

task automatic five_chunk_job();
    int errs_before;
    errs_before = err_count;
    set_delays(0, 0, 0, 0);
    run_job(5, 32'h0001_2344, 32'h0003_a0c4);
    check_writes(5, 32'h0001_2344, 32'h0003_a0c4);
    finish_test("five chunks", errs_before);
endtask

task automatic random_delay_job();
    int errs_before;
    errs_before = err_count;
    set_delays(worst_delay, worst_delay, worst_delay, 0);
    run_job(3, 32'h0002_0010, 32'h0004_0f00);
    check_writes(3, 32'h0002_0010, 32'h0004_0f00);
    finish_test("random delays", errs_before);
endtask

// Lane 1 far behind lane 0
task automatic slow_lane1_job();
    int errs_before;
    errs_before = err_count;
    set_delays(0, 0, 0, slow_delay);
    run_job(3, 32'h0005_0000, 32'h0006_1234);
    check_writes(3, 32'h0005_0000, 32'h0006_1234);
    finish_test("slow lane 1", errs_before);
endtask

task automatic back_to_back_jobs();
    int errs_before;
    errs_before = err_count;
    set_delays(2, 2, 2, 0);
    run_job(2, 32'h0007_0040, 32'h0008_0080);
    check_writes(2, 32'h0007_0040, 32'h0008_0080);
    run_job(3, 32'h0009_00a4, 32'h000a_0c08);
    check_writes(3, 32'h0009_00a4, 32'h000a_0c08);
    finish_test("back to back jobs", errs_before);
endtask

`endif

/* test/tb_aes_dma.sv */
`timescale 1ns/1ps

module tb_aes_dma;

    localparam int words_per_chunk = 8;
    localparam int total_chunks    = 17;
    localparam int worst_delay     = 7;
    localparam int slow_delay      = 40;
    // Every read and write handshake at worst delay, plus the slow lane and margin
    localparam int cycle_limit = total_chunks * 2 * words_per_chunk * 2 * (worst_delay + 3)
                               + total_chunks * 2 * slow_delay + 500;

    // Engine model result is block ^ eng_key
    localparam logic [127:0] eng_key = 128'h3c6e_f372_a54f_f53a_510e_527f_9b05_688c;

    logic         aes_clk = 1'b0;
    logic         aes_rst_n;
    logic         start;
    logic [31:0]  num_chunks;
    logic [31:0]  rd_base;
    logic [31:0]  wr_base;
    logic         complete;
    logic         rd_req;
    logic [31:0]  rd_addr;
    logic         rd_ack;
    logic [31:0]  rd_data;
    logic         wr_req;
    logic [31:0]  wr_addr;
    logic [31:0]  wr_data;
    logic         wr_ack;
    logic         eng0_req;
    logic [127:0] eng0_block;
    logic         eng0_ack;
    logic [127:0] eng0_result;
    logic         eng1_req;
    logic [127:0] eng1_block;
    logic         eng1_ack;
    logic [127:0] eng1_result;

    logic [31:0]  mem [logic [31:0]];
    logic [31:0]  wr_log_addr [$];
    logic [31:0]  wr_log_data [$];
    logic [31:0]  lfsr_state = 32'h2000_310d;

    int rd_max_delay = 0;
    int wr_max_delay = 0;
    int eng_max_delay = 0;
    int eng1_extra = 0;
    int complete_cnt = 0;
    int err_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_cnt = 0;

    always #5 aes_clk = ~aes_clk;

    aes_dma_top u_dut (
        .aes_clk    (aes_clk),
        .aes_rst_n  (aes_rst_n),
        .start      (start),
        .num_chunks (num_chunks),
        .rd_base    (rd_base),
        .wr_base    (wr_base),
        .complete   (complete),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_ack     (rd_ack),
        .rd_data    (rd_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_ack     (wr_ack),
        .eng0_req   (eng0_req),
        .eng0_block (eng0_block),
        .eng0_ack   (eng0_ack),
        .eng0_result(eng0_result),
        .eng1_req   (eng1_req),
        .eng1_block (eng1_block),
        .eng1_ack   (eng1_ack),
        .eng1_result(eng1_result)
    );

    //////////////////////////////
    // Random numbers
    //////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic int pick_delay(input int max_d, input int extra);
        if (max_d == 0) begin
            return extra;
        end
        return extra + rand_bits(3) % (max_d + 1);
    endfunction

    //////////////////////////////
    // Memory and engine models
    //////////////////////////////

    // Unwritten words still depend on the whole address
    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a_c3c3;
    endfunction

    initial begin : rd_model
        int d;
        rd_ack  <= 1'b0;
        rd_data <= '0;
        forever begin
            @(posedge aes_clk);
            if (rd_req && !rd_ack) begin
                d = pick_delay(rd_max_delay, 0);
                repeat (d) @(posedge aes_clk);
                rd_data <= read_word(rd_addr);
                rd_ack  <= 1'b1;
            end else if (!rd_req && rd_ack) begin
                rd_ack <= 1'b0;
            end
        end
    end

    initial begin : wr_model
        int d;
        wr_ack <= 1'b0;
        forever begin
            @(posedge aes_clk);
            if (wr_req && !wr_ack) begin
                d = pick_delay(wr_max_delay, 0);
                repeat (d) @(posedge aes_clk);
                mem[wr_addr] = wr_data;
                wr_log_addr.push_back(wr_addr);
                wr_log_data.push_back(wr_data);
                wr_ack <= 1'b1;
            end else if (!wr_req && wr_ack) begin
                wr_ack <= 1'b0;
            end
        end
    end

    initial begin : eng0_model
        int d;
        eng0_ack    <= 1'b0;
        eng0_result <= '0;
        forever begin
            @(posedge aes_clk);
            if (eng0_req && !eng0_ack) begin
                d = pick_delay(eng_max_delay, 0);
                repeat (d) @(posedge aes_clk);
                eng0_result <= eng0_block ^ eng_key;
                eng0_ack    <= 1'b1;
            end else if (!eng0_req && eng0_ack) begin
                eng0_ack <= 1'b0;
            end
        end
    end

    initial begin : eng1_model
        int d;
        eng1_ack    <= 1'b0;
        eng1_result <= '0;
        forever begin
            @(posedge aes_clk);
            if (eng1_req && !eng1_ack) begin
                d = pick_delay(eng_max_delay, eng1_extra);
                repeat (d) @(posedge aes_clk);
                eng1_result <= eng1_block ^ eng_key;
                eng1_ack    <= 1'b1;
            end else if (!eng1_req && eng1_ack) begin
                eng1_ack <= 1'b0;
            end
        end
    end

    // Counted on the falling edge, where complete is settled
    always @(negedge aes_clk) begin
        if (complete) begin
            complete_cnt++;
        end
    end

    //////////////////////////////
    // Test helpers
    //////////////////////////////

    task automatic report_err(input string msg);
        err_count++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic set_delays(input int rd_d, input int wr_d, input int eng_d, input int slow);
        rd_max_delay  = rd_d;
        wr_max_delay  = wr_d;
        eng_max_delay = eng_d;
        eng1_extra    = slow;
    endtask

    task automatic fill_source(input logic [31:0] base, input int n);
        for (int i = 0; i < n * words_per_chunk; i++) begin
            mem[base + 4 * i] = rand_bits(32);
        end
    endtask

    // One job from start pulse to complete, then a few idle cycles
    task automatic run_job(input int n, input logic [31:0] rbase, input logic [31:0] wbase);
        int pulses_before;
        fill_source(rbase, n);
        wr_log_addr.delete();
        wr_log_data.delete();
        pulses_before = complete_cnt;
        @(posedge aes_clk);
        num_chunks <= n;
        rd_base    <= rbase;
        wr_base    <= wbase;
        start      <= 1'b1;
        @(posedge aes_clk);
        start <= 1'b0;
        while (complete_cnt == pulses_before) begin
            @(posedge aes_clk);
        end
        repeat (5) @(posedge aes_clk);
        if (complete_cnt - pulses_before != 1) begin
            report_err($sformatf("complete pulsed %0d times for one job",
                                 complete_cnt - pulses_before));
        end
    endtask

    `include "tb_aes_dma_tests.svh"

    initial begin
        start      <= 1'b0;
        num_chunks <= '0;
        rd_base    <= '0;
        wr_base    <= '0;
        aes_rst_n  <= 1'b0;
        repeat (10) @(posedge aes_clk);
        aes_rst_n <= 1'b1;
        idle_after_reset();
        single_chunk_job();
        five_chunk_job();
        random_delay_job();
        slow_lane1_job();
        back_to_back_jobs();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < cycle_limit) begin
            @(posedge aes_clk);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* flist.f */
+incdir+logic
+incdir+test
logic/aes_mem_pkg.sv
logic/aes_block_pkg.sv
logic/chunk_reader.sv
logic/cipher_lane.sv
logic/result_writer.sv
logic/aes_dma_top.sv
test/tb_aes_dma.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log" build.log

verilator --binary --timing --assert \
    -f flist.f --top-module tb_aes_dma -o tb_aes_dma \
    > build.log 2>&1 \
    && ./obj_dir/tb_aes_dma > "$log" 2>&1 \
    || { cat build.log; echo "Build or simulation stopped with an error"; }

[ -f "$log" ] && cat "$log"

grep -qx "=== PASS ===" "$log" 2>/dev/null \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
